//--- rtl/pipe_ctrl_cfg.svh
// pipeline control configuration with word width, trap vector and interrupt cause
`ifndef PIPE_CTRL_CFG_SVH
`define PIPE_CTRL_CFG_SVH

// machine word width
`define XLEN 32

// fixed machine trap vector (direct mode only)
`define MTVEC_ADDR 32'h0000_0100

// machine external interrupt cause code
`define IRQ_CAUSE 11

`endif

//--- rtl/pipe_ctrl_pkg.sv
// pipeline control package holding the word, register index and cause types
`include "pipe_ctrl_cfg.svh"

package pipe_ctrl_pkg;

    // pc, epc and csr words
    typedef logic [`XLEN-1:0] word_t;

    // architectural register index, x0..x31
    typedef logic [4:0] reg_idx_t;

    // exception codes as written to mcause
    typedef enum logic [3:0] {
        insn_misaligned  = 4'd0,
        insn_fault       = 4'd1,
        illegal_insn     = 4'd2,
        breakpoint       = 4'd3,
        load_misaligned  = 4'd4,
        load_fault       = 4'd5,
        store_misaligned = 4'd6,
        store_fault      = 4'd7,
        env_call_m       = 4'd11 // ecall from m-mode
    } cause_t;

endpackage

//--- rtl/hazard_if.sv
// hazard interface carrying pipeline status in and stall/flush controls out
`timescale 1ns/1ps

interface hazard_if;

    // operand and writeback info
    pipe_ctrl_pkg::reg_idx_t rs1_e;
    pipe_ctrl_pkg::reg_idx_t rs2_e;
    pipe_ctrl_pkg::reg_idx_t rd_m;
    logic reg_write, dren, dwen, csr_read;
    logic jump, branch, mispredict; // control flow from execute
    logic i_mem_busy, d_mem_busy, rv32c_ready, ex_busy;
    logic halt, ifence, fence_stall;
    // fault flags, one per exception source
    logic mal_insn, fault_insn, illegal_insn, breakpoint;
    logic mal_l, fault_l, mal_s, fault_s;
    logic env, ret;
    logic valid_m, valid_e;
    pipe_ctrl_pkg::word_t pc_f, pc_e, pc_m; // per stage pc for epc selection

    // controls back to the datapath
    logic pc_en, npc_sel;
    logic if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush, mem_use_stall;
    logic suppress_iren, suppress_data, rollback;
    logic insert_priv_pc;
    pipe_ctrl_pkg::word_t priv_pc;

    modport hazard_unit (
        input rs1_e, rs2_e, rd_m, reg_write, dren, dwen, csr_read, jump, branch, mispredict,
              i_mem_busy, d_mem_busy, rv32c_ready, ex_busy, halt, ifence, fence_stall,
              mal_insn, fault_insn, illegal_insn, breakpoint, mal_l, fault_l, mal_s, fault_s,
              env, ret, valid_m, valid_e, pc_f, pc_e, pc_m,
        output pc_en, npc_sel, if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush,
               mem_use_stall, suppress_iren, suppress_data, rollback, insert_priv_pc, priv_pc
    );

    modport top (
        output rs1_e, rs2_e, rd_m, reg_write, dren, dwen, csr_read, jump, branch, mispredict,
               i_mem_busy, d_mem_busy, rv32c_ready, ex_busy, halt, ifence, fence_stall,
               mal_insn, fault_insn, illegal_insn, breakpoint, mal_l, fault_l, mal_s, fault_s,
               env, ret, valid_m, valid_e, pc_f, pc_e, pc_m,
        input pc_en, npc_sel, if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush,
              mem_use_stall, suppress_iren, suppress_data, rollback, insert_priv_pc, priv_pc
    );

endinterface

//--- rtl/trap_if.sv
// trap interface carrying exception requests and epc in, pc redirects out
`timescale 1ns/1ps

interface trap_if;

    // exception sources forwarded by the hazard unit
    logic mal_insn, fault_insn, illegal_insn, breakpoint;
    logic mal_l, fault_l, mal_s, fault_s;
    logic env;
    logic ret;                   // mret seen in the pipe
    pipe_ctrl_pkg::word_t epc;   // pc of the oldest live insn
    logic wb_enable;             // trap may commit, no data access pending

    // trap unit responses
    logic intr;                  // irq masked by mie
    logic insert_pc;             // one cycle redirect pulse
    pipe_ctrl_pkg::word_t priv_pc;

    modport hazard (
        output mal_insn, fault_insn, illegal_insn, breakpoint, mal_l, fault_l, mal_s, fault_s,
               env, ret, epc, wb_enable,
        input intr, insert_pc, priv_pc
    );

    modport trap (
        input mal_insn, fault_insn, illegal_insn, breakpoint, mal_l, fault_l, mal_s, fault_s,
              env, ret, epc, wb_enable,
        output intr, insert_pc, priv_pc
    );

endinterface

//--- rtl/hazard_unit.sv
// hazard unit computing stall, flush and pc enable for the three-stage pipeline
`timescale 1ns/1ps

module hazard_unit (
    input logic clk,
    hazard_if.hazard_unit hazard,
    trap_if.hazard trap
);

    logic rs1_match;
    logic rs2_match;
    logic cannot_forward;
    logic dmem_access;
    logic branch_jump;
    logic wait_for_imem;
    logic wait_for_dmem;
    logic exception;
    logic intr;
    logic ex_flush_hazard;
    pipe_ctrl_pkg::word_t epc;

    // data hazard detection against the mem stage destination
    assign rs1_match = (hazard.rs1_e == hazard.rd_m) && (hazard.rd_m != '0);
    assign rs2_match = (hazard.rs2_e == hazard.rd_m) && (hazard.rd_m != '0);
    assign cannot_forward = hazard.dren || hazard.csr_read; // result only known after mem
    assign hazard.mem_use_stall = hazard.reg_write && cannot_forward && (rs1_match || rs2_match);

    assign dmem_access = hazard.dren || hazard.dwen;
    assign branch_jump = hazard.jump || (hazard.branch && hazard.mispredict);
    // early compressed insn means fetch is not really waiting
    assign wait_for_imem = hazard.i_mem_busy && !hazard.suppress_iren && !hazard.rv32c_ready;
    assign wait_for_dmem = dmem_access && hazard.d_mem_busy && !hazard.suppress_data;

    assign hazard.npc_sel = branch_jump;

    // exceptions always win over an interrupt in the same cycle
    assign exception = hazard.mal_insn || hazard.fault_insn || hazard.illegal_insn
                     || hazard.breakpoint || hazard.mal_l || hazard.fault_l
                     || hazard.mal_s || hazard.fault_s || hazard.env;
    assign intr = !exception && trap.intr;

    // interrupt waits for an outstanding data access, exceptions do not
    assign ex_flush_hazard = ((intr || exception) && !wait_for_dmem)
                           || exception
                           || hazard.ret
                           || (hazard.ifence && !hazard.fence_stall); // refetch after ifence

    assign hazard.suppress_iren = branch_jump || ex_flush_hazard || trap.insert_pc;
    assign hazard.suppress_data = exception; // keep faulting access off the bus
    assign hazard.rollback = hazard.ifence && !hazard.fence_stall;

    // oldest valid insn gets the epc, interrupts point past a finishing mem op
    assign epc = (hazard.valid_m && (!intr || branch_jump)) ? hazard.pc_m :
                 (hazard.valid_e ? hazard.pc_e : hazard.pc_f);

    // forward requests to the trap unit
    assign trap.mal_insn     = hazard.mal_insn;
    assign trap.fault_insn   = hazard.fault_insn;
    assign trap.illegal_insn = hazard.illegal_insn;
    assign trap.breakpoint   = hazard.breakpoint;
    assign trap.mal_l        = hazard.mal_l;
    assign trap.fault_l      = hazard.fault_l;
    assign trap.mal_s        = hazard.mal_s;
    assign trap.fault_s      = hazard.fault_s;
    assign trap.env          = hazard.env;
    assign trap.ret          = hazard.ret;
    assign trap.epc          = epc;
    assign trap.wb_enable    = !wait_for_dmem; // a pending load/store must land first

    // redirect from the trap unit straight to fetch
    assign hazard.insert_priv_pc = trap.insert_pc;
    assign hazard.priv_pc        = trap.priv_pc;

    // pc moves when fetch can hand off, or on any forced redirect
    assign hazard.pc_en = (!hazard.if_ex_stall && !wait_for_imem)
                        || branch_jump
                        || ex_flush_hazard
                        || trap.insert_pc;

    assign hazard.if_ex_flush = ex_flush_hazard
                              || branch_jump
                              || (wait_for_imem && !hazard.ex_mem_stall); // bubble while fetch lags

    // if_ex held but ex_mem moving, insert a bubble behind it
    assign hazard.ex_mem_flush = ex_flush_hazard
                               || branch_jump
                               || (hazard.if_ex_stall && !hazard.ex_mem_stall);

    // stall priority over flush when execute is busy, unless control flow changes
    assign hazard.if_ex_stall = !intr && (hazard.ex_mem_stall
                              || (hazard.ex_busy && !ex_flush_hazard && !branch_jump)
                              || hazard.mem_use_stall
                              || hazard.fence_stall);

    assign hazard.ex_mem_stall = wait_for_dmem || hazard.fence_stall || hazard.halt;

    // a stalled back end must hold the front end too
    a_stall_order : assert property (@(posedge clk)
        hazard.ex_mem_stall && !trap.intr |-> hazard.if_ex_stall);

    // squashed data access always takes the mem stage insn with it
    a_suppress_flush : assert property (@(posedge clk)
        hazard.suppress_data |-> hazard.ex_mem_flush && hazard.if_ex_flush);

endmodule

//--- rtl/trap_unit.sv
// machine trap unit holding mepc, mcause and mie and redirecting fetch
`timescale 1ns/1ps
`include "pipe_ctrl_cfg.svh"

module trap_unit (
    input logic clk,
    input logic reset,
    input logic irq,
    trap_if.trap trap,
    output pipe_ctrl_pkg::word_t mepc,
    output pipe_ctrl_pkg::word_t mcause
);

    logic mie;                         // machine interrupt enable
    logic exception;
    logic take_trap;
    logic take_ret;
    pipe_ctrl_pkg::cause_t cause;
    pipe_ctrl_pkg::word_t cause_word;
    pipe_ctrl_pkg::word_t redirect_pc; // target held for the pulse cycle

    assign trap.intr = irq && mie;

    assign exception = trap.mal_insn || trap.fault_insn || trap.illegal_insn
                     || trap.breakpoint || trap.env || trap.mal_l || trap.fault_l
                     || trap.mal_s || trap.fault_s;

    // stages were flushed at the trap edge, so the redirect cycle carries only bubbles
    assign take_trap = !trap.insert_pc && trap.wb_enable && (exception || trap.intr);
    assign take_ret  = !trap.insert_pc && !take_trap && trap.ret;

    // fetch side faults first, then decode, then memory
    always_comb begin
        cause = pipe_ctrl_pkg::store_fault;
        if (trap.mal_insn)
            cause = pipe_ctrl_pkg::insn_misaligned;
        else if (trap.fault_insn)
            cause = pipe_ctrl_pkg::insn_fault;
        else if (trap.illegal_insn)
            cause = pipe_ctrl_pkg::illegal_insn;
        else if (trap.breakpoint)
            cause = pipe_ctrl_pkg::breakpoint;
        else if (trap.env)
            cause = pipe_ctrl_pkg::env_call_m;
        else if (trap.mal_l)
            cause = pipe_ctrl_pkg::load_misaligned;
        else if (trap.fault_l)
            cause = pipe_ctrl_pkg::load_fault;
        else if (trap.mal_s)
            cause = pipe_ctrl_pkg::store_misaligned;
    end

    // interrupt flag in the msb
    assign cause_word = exception ? {{(`XLEN-4){1'b0}}, cause}
                                  : {1'b1, {(`XLEN-5){1'b0}}, 4'(`IRQ_CAUSE)};

    always_ff @(posedge clk) begin
        if (reset) begin
            mie            <= 1'b1;
            mepc           <= '0;
            mcause         <= '0;
            trap.insert_pc <= 1'b0;
        end else begin
            trap.insert_pc <= take_trap || take_ret; // single cycle, never held
            if (take_trap) begin
                mepc   <= trap.epc;
                mcause <= cause_word;
                mie    <= 1'b0;   // no nested interrupts
            end else if (take_ret) begin
                mie <= 1'b1;
            end
        end
    end

    // redirect target, only looked at while insert_pc is high
    always_ff @(posedge clk) begin
        if (take_trap)
            redirect_pc <= `MTVEC_ADDR;
        else if (take_ret)
            redirect_pc <= mepc;
    end

    assign trap.priv_pc = redirect_pc;

    a_single_redirect : assert property (@(posedge clk) disable iff (reset)
        trap.insert_pc |=> !trap.insert_pc);

endmodule

//--- rtl/pipe_ctrl_top.sv
// pipeline control top level joining the hazard unit and the trap unit
`timescale 1ns/1ps

module pipe_ctrl_top (
    input  logic clk,
    input  logic reset,
    input  logic irq,
    input  pipe_ctrl_pkg::reg_idx_t rs1_e, rs2_e, rd_m,
    input  logic reg_write, dren, dwen, csr_read,
    input  logic jump, branch, mispredict,
    input  logic i_mem_busy, d_mem_busy, rv32c_ready, ex_busy,
    input  logic halt, ifence, fence_stall,
    input  logic mal_insn, fault_insn, illegal_insn, breakpoint,
    input  logic mal_l, fault_l, mal_s, fault_s,
    input  logic env, ret,
    input  logic valid_m, valid_e,
    input  pipe_ctrl_pkg::word_t pc_f, pc_e, pc_m,
    output logic pc_en, npc_sel,
    output logic if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush,
    output logic suppress_iren, suppress_data, rollback,
    output logic insert_priv_pc,
    output pipe_ctrl_pkg::word_t priv_pc,
    output pipe_ctrl_pkg::word_t mepc,
    output pipe_ctrl_pkg::word_t mcause
);

    hazard_if hazard_bus ();
    trap_if   trap_bus ();

    // pipeline status into the hazard bundle
    assign hazard_bus.rs1_e        = rs1_e;
    assign hazard_bus.rs2_e        = rs2_e;
    assign hazard_bus.rd_m         = rd_m;
    assign hazard_bus.reg_write    = reg_write;
    assign hazard_bus.dren         = dren;
    assign hazard_bus.dwen         = dwen;
    assign hazard_bus.csr_read     = csr_read;
    assign hazard_bus.jump         = jump;
    assign hazard_bus.branch       = branch;
    assign hazard_bus.mispredict   = mispredict;
    assign hazard_bus.i_mem_busy   = i_mem_busy;
    assign hazard_bus.d_mem_busy   = d_mem_busy;
    assign hazard_bus.rv32c_ready  = rv32c_ready;
    assign hazard_bus.ex_busy      = ex_busy;
    assign hazard_bus.halt         = halt;
    assign hazard_bus.ifence       = ifence;
    assign hazard_bus.fence_stall  = fence_stall;
    assign hazard_bus.mal_insn     = mal_insn;
    assign hazard_bus.fault_insn   = fault_insn;
    assign hazard_bus.illegal_insn = illegal_insn;
    assign hazard_bus.breakpoint   = breakpoint;
    assign hazard_bus.mal_l        = mal_l;
    assign hazard_bus.fault_l      = fault_l;
    assign hazard_bus.mal_s        = mal_s;
    assign hazard_bus.fault_s      = fault_s;
    assign hazard_bus.env          = env;
    assign hazard_bus.ret          = ret;
    assign hazard_bus.valid_m      = valid_m;
    assign hazard_bus.valid_e      = valid_e;
    assign hazard_bus.pc_f         = pc_f;
    assign hazard_bus.pc_e         = pc_e;
    assign hazard_bus.pc_m         = pc_m;

    // controls out, mem_use_stall stays on the bundle
    assign pc_en          = hazard_bus.pc_en;
    assign npc_sel        = hazard_bus.npc_sel;
    assign if_ex_stall    = hazard_bus.if_ex_stall;
    assign if_ex_flush    = hazard_bus.if_ex_flush;
    assign ex_mem_stall   = hazard_bus.ex_mem_stall;
    assign ex_mem_flush   = hazard_bus.ex_mem_flush;
    assign suppress_iren  = hazard_bus.suppress_iren;
    assign suppress_data  = hazard_bus.suppress_data;
    assign rollback       = hazard_bus.rollback;
    assign insert_priv_pc = hazard_bus.insert_priv_pc;
    assign priv_pc        = hazard_bus.priv_pc;

    hazard_unit hazard_unit_inst (
        .clk    (clk),
        .hazard (hazard_bus.hazard_unit),
        .trap   (trap_bus.hazard)
    );

    trap_unit trap_unit_inst (
        .clk    (clk),
        .reset  (reset),
        .irq    (irq),
        .trap   (trap_bus.trap),
        .mepc   (mepc),
        .mcause (mcause)
    );

endmodule

//--- test/tb_pipe_ctrl.sv
// testbench for the pipeline control block with lfsr stimulus and a cycle model
`timescale 1ns/1ps
`include "pipe_ctrl_cfg.svh"

module tb_pipe_ctrl;

    logic clk, reset, irq;
    pipe_ctrl_pkg::reg_idx_t rs1_e, rs2_e, rd_m;
    logic reg_write, dren, dwen, csr_read, jump, branch, mispredict;
    logic i_mem_busy, d_mem_busy, rv32c_ready, ex_busy, halt, ifence, fence_stall;
    logic mal_insn, fault_insn, illegal_insn, breakpoint, mal_l, fault_l, mal_s, fault_s;
    logic env, ret, valid_m, valid_e;
    pipe_ctrl_pkg::word_t pc_f, pc_e, pc_m;
    logic pc_en, npc_sel, if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush;
    logic suppress_iren, suppress_data, rollback, insert_priv_pc;
    pipe_ctrl_pkg::word_t priv_pc, mepc, mcause;

    // model state, updated for the edge that ends each cycle
    logic m_mie, m_pending;
    pipe_ctrl_pkg::word_t m_mepc, m_mcause, m_target;

    logic [31:0] lfsr;
    string cur_test;
    int errors, checks, tests, test_errors, test_cycles;

    pipe_ctrl_top pipe_ctrl_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr); // one step per bit
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic rare(input int n);
        return take_bits(n) == 32'd0; // odds of 1 in 2**n
    endfunction

    function automatic logic coin();
        return take_bits(1) != 32'd0;
    endfunction

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s %s expected 0x%08h actual 0x%08h",
                     cur_test, what, expected, actual);
        end
    endtask

    // cause word by priority, fetch faults first and memory faults last
    function automatic pipe_ctrl_pkg::word_t expected_cause();
        if (mal_insn) return 32'd0;
        if (fault_insn) return 32'd1;
        if (illegal_insn) return 32'd2;
        if (breakpoint) return 32'd3;
        if (env) return 32'd11;
        if (mal_l) return 32'd4;
        if (fault_l) return 32'd5;
        if (mal_s) return 32'd6;
        if (fault_s) return 32'd7;
        return 32'h8000_0000 + 32'(`IRQ_CAUSE); // interrupt only
    endfunction

    task automatic clear_inputs();
        irq = 1'b0;
        {rs1_e, rs2_e, rd_m} = '0;
        {reg_write, dren, dwen, csr_read, jump, branch, mispredict} = '0;
        {i_mem_busy, d_mem_busy, rv32c_ready, ex_busy, halt, ifence, fence_stall} = '0;
        {mal_insn, fault_insn, illegal_insn, breakpoint, mal_l, fault_l, mal_s, fault_s} = '0;
        {env, ret, valid_m, valid_e} = '0;
        pc_f = 32'h0000_1008;
        pc_e = 32'h0000_1004;
        pc_m = 32'h0000_1000;
    endtask

    task automatic random_inputs();
        rs1_e = 5'(take_bits(2)); // narrow indices so matches and x0 show up often
        rs2_e = 5'(take_bits(2));
        rd_m = 5'(take_bits(2));
        reg_write = coin();
        dren = coin();
        dwen = rare(2);
        csr_read = rare(2);
        jump = rare(3);
        branch = coin();
        mispredict = coin();
        i_mem_busy = rare(2);
        d_mem_busy = coin();
        rv32c_ready = coin();
        ex_busy = rare(2);
        halt = rare(4);
        ifence = rare(4);
        fence_stall = rare(4);
        mal_insn = rare(6);
        fault_insn = rare(6);
        illegal_insn = rare(6);
        breakpoint = rare(6);
        mal_l = rare(6);
        fault_l = rare(6);
        mal_s = rare(6);
        fault_s = rare(6);
        env = rare(6);
        ret = rare(5);
        irq = rare(3);
        valid_m = coin();
        valid_e = coin();
        pc_f = take_bits(30) << 2;
        pc_e = take_bits(30) << 2;
        pc_m = take_bits(30) << 2;
    endtask

    task automatic set_fault(input int i);
        case (i)
            0: mal_insn = 1'b1;
            1: fault_insn = 1'b1;
            2: illegal_insn = 1'b1;
            3: breakpoint = 1'b1;
            4: env = 1'b1;
            5: mal_l = 1'b1;
            6: fault_l = 1'b1;
            7: mal_s = 1'b1;
            default: fault_s = 1'b1;
        endcase
    endtask

    // inputs change shortly after the rising edge
    task automatic begin_cycle();
        @(posedge clk);
        #2;
        clear_inputs();
    endtask

    // compare at the falling edge, then advance the model past the next rising edge
    task automatic end_cycle();
        logic exc, intr_raw, intr, wait_d, wait_i, bj, efh, mus, ems, ifs, sup_i;
        logic take_trap, take_ret;
        pipe_ctrl_pkg::word_t epc;
        @(negedge clk);
        test_cycles++;
        exc = mal_insn || fault_insn || illegal_insn || breakpoint || env
            || mal_l || fault_l || mal_s || fault_s;
        intr_raw = irq && m_mie;
        intr = intr_raw && !exc;                             // exceptions win
        wait_d = (dren || dwen) && d_mem_busy && !exc;       // faulting access is squashed
        bj = jump || (branch && mispredict);
        efh = (intr && !wait_d) || exc || ret || (ifence && !fence_stall);
        sup_i = bj || efh || m_pending;
        wait_i = i_mem_busy && !sup_i && !rv32c_ready;
        mus = reg_write && (dren || csr_read) && (rd_m != '0)
            && (rs1_e == rd_m || rs2_e == rd_m);
        ems = wait_d || fence_stall || halt;
        ifs = !intr && (ems || (ex_busy && !efh && !bj) || mus || fence_stall);

        check("npc_sel", 32'(bj), 32'(npc_sel));
        check("pc_en", 32'((!ifs && !wait_i) || bj || efh || m_pending), 32'(pc_en));
        check("if_ex_stall", 32'(ifs), 32'(if_ex_stall));
        check("ex_mem_stall", 32'(ems), 32'(ex_mem_stall));
        check("if_ex_flush", 32'(efh || bj || (wait_i && !ems)), 32'(if_ex_flush));
        check("ex_mem_flush", 32'(efh || bj || (ifs && !ems)), 32'(ex_mem_flush));
        check("suppress_iren", 32'(sup_i), 32'(suppress_iren));
        check("suppress_data", 32'(exc), 32'(suppress_data));
        check("rollback", 32'(ifence && !fence_stall), 32'(rollback));
        check("insert_priv_pc", 32'(m_pending), 32'(insert_priv_pc));
        if (m_pending)
            check("priv_pc", m_target, priv_pc); // target only defined during the pulse
        check("mepc", m_mepc, mepc);
        check("mcause", m_mcause, mcause);

        epc = (valid_m && (!intr || bj)) ? pc_m : (valid_e ? pc_e : pc_f);
        take_trap = !m_pending && !wait_d && (exc || intr_raw);
        take_ret = !m_pending && !take_trap && ret;
        m_pending = take_trap || take_ret;
        if (take_trap) begin
            m_target = `MTVEC_ADDR;
            m_mepc = epc;
            m_mcause = expected_cause();
            m_mie = 1'b0;
        end else if (take_ret) begin
            m_target = m_mepc; // old mepc, before any update
            m_mie = 1'b1;
        end
    endtask

    task automatic wait_redirect(input int limit);
        int n;
        n = 0;
        do begin
            begin_cycle();
            end_cycle();
            n++;
        end while (!insert_priv_pc && n < limit);
        if (!insert_priv_pc) begin
            errors++;
            $display("timeout in %s: no pc redirect within %0d cycles", cur_test, limit);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errors = errors;
        test_cycles = 0;
    endtask

    task automatic finish_test();
        tests++;
        if (errors == test_errors)
            $display("test %-10s ok     %0d cycles", cur_test, test_cycles);
        else
            $display("test %-10s failed %0d cycles, %0d errors", cur_test, test_cycles,
                     errors - test_errors);
    endtask

    initial begin
        lfsr = 32'h49f0_8e92;
        {errors, checks, tests} = '0;
        m_mie = 1'b1;     // reset values of the trap unit
        m_pending = 1'b0;
        m_mepc = '0;
        m_mcause = '0;
        m_target = '0;
        reset = 1'b1;
        clear_inputs();
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;

        start_test("load_use");
        begin_cycle();
        reg_write = 1'b1;
        dren = 1'b1;
        rd_m = 5'd7;
        rs1_e = 5'd7;
        end_cycle();
        begin_cycle();
        reg_write = 1'b1;
        csr_read = 1'b1;
        rd_m = 5'd9;
        rs2_e = 5'd9;
        end_cycle();
        begin_cycle();
        reg_write = 1'b1;
        dren = 1'b1;
        d_mem_busy = 1'b1;  // data memory waiting, no bubble into mem
        rd_m = 5'd3;
        rs1_e = 5'd3;
        end_cycle();
        begin_cycle();
        reg_write = 1'b1;
        dren = 1'b1;        // x0 never stalls
        end_cycle();
        finish_test();

        start_test("control");
        begin_cycle();
        jump = 1'b1;
        end_cycle();
        begin_cycle();
        branch = 1'b1;
        mispredict = 1'b1;
        end_cycle();
        begin_cycle();
        branch = 1'b1;      // predicted right, no redirect
        end_cycle();
        finish_test();

        start_test("waits");
        begin_cycle();
        dwen = 1'b1;
        d_mem_busy = 1'b1;
        end_cycle();
        begin_cycle();
        i_mem_busy = 1'b1;
        end_cycle();
        begin_cycle();
        i_mem_busy = 1'b1;
        rv32c_ready = 1'b1;
        end_cycle();
        begin_cycle();
        i_mem_busy = 1'b1;
        halt = 1'b1;        // back end held, fetch bubble not inserted
        end_cycle();
        finish_test();

        start_test("ifence");
        begin_cycle();
        ifence = 1'b1;
        end_cycle();
        begin_cycle();
        ifence = 1'b1;
        fence_stall = 1'b1;
        end_cycle();
        finish_test();

        start_test("exception");
        for (int i = 0; i < 9; i++) begin
            begin_cycle();
            set_fault(i);
            valid_m = (i % 2 == 0);
            valid_e = 1'b1;
            end_cycle();
            wait_redirect(4);
        end
        begin_cycle();
        mal_l = 1'b1;
        fault_s = 1'b1;
        env = 1'b1;         // env ranks above the memory faults
        valid_m = 1'b1;
        end_cycle();
        wait_redirect(4);
        finish_test();

        start_test("irq_ret");
        begin_cycle();
        ret = 1'b1;         // mie was cleared by the exceptions above
        end_cycle();
        wait_redirect(4);
        begin_cycle();
        irq = 1'b1;
        valid_m = 1'b1;
        valid_e = 1'b1;
        end_cycle();
        wait_redirect(4);
        repeat (3) begin
            begin_cycle();
            irq = 1'b1;     // masked until mret
            end_cycle();
        end
        begin_cycle();
        ret = 1'b1;
        end_cycle();
        wait_redirect(4);
        begin_cycle();
        irq = 1'b1;
        valid_e = 1'b1;
        end_cycle();
        wait_redirect(4);
        finish_test();

        start_test("random");
        repeat (3000) begin
            begin_cycle();
            random_inputs();
            end_cycle();
        end
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+rtl
rtl/pipe_ctrl_pkg.sv
rtl/hazard_if.sv
rtl/trap_if.sv
rtl/hazard_unit.sv
rtl/trap_unit.sv
rtl/pipe_ctrl_top.sv
test/tb_pipe_ctrl.sv

//--- Makefile
# Verilator flow for the pipeline control testbench
VERILATOR ?= verilator
TOP       ?= tb_pipe_ctrl
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= STATUS: PASS

SOURCES := $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# output goes to the console and is searched for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
